/* verilog/pw_pkg.sv */
// Shared types, register map, FIFO entry layout, command codes and status bits
package pw_pkg;

   typedef logic [5:0]  addr_t;
   typedef logic [6:0]  bytecnt_t;
   typedef logic [7:0]  byte_t;
   typedef logic [17:0] entry_t;
   typedef logic [15:0] ftime_t;
   typedef logic [63:0] pattern_t;
   typedef logic [19:0] tdelay_t;
   typedef logic [15:0] twidth_t;
   typedef logic [15:0] caplen_t;
   typedef logic [1:0]  speed_t;
   typedef logic [1:0]  cmd_t;
   typedef logic [4:0]  stat_t;
   typedef logic [5:0]  fifo_status_t;

   // Register map
   localparam addr_t REG_ARM                = 6'h01;
   localparam addr_t REG_TIMESTAMPS_DISABLE = 6'h02;
   localparam addr_t REG_PATTERN            = 6'h03;
   localparam addr_t REG_PATTERN_MASK       = 6'h04;
   localparam addr_t REG_PATTERN_ACTION     = 6'h05;
   localparam addr_t REG_PATTERN_BYTES      = 6'h06;
   localparam addr_t REG_CAPTURE_LEN        = 6'h07;
   localparam addr_t REG_TRIGGER_DELAY      = 6'h08;
   localparam addr_t REG_TRIGGER_WIDTH      = 6'h09;
   localparam addr_t REG_USB_SPEED          = 6'h0a;
   localparam addr_t REG_SNIFF_FIFO_STAT    = 6'h0b;
   localparam addr_t REG_SNIFF_FIFO_RD      = 6'h0c;

   // Capture commands, top two bits of an entry
   localparam cmd_t CMD_DATA = 2'd0;
   localparam cmd_t CMD_STAT = 2'd1;
   localparam cmd_t CMD_TIME = 2'd2;
   localparam cmd_t CMD_STRM = 2'd3;

   localparam byte_t  STRM_EMPTY     = 8'd1;
   localparam speed_t USB_SPEED_AUTO = 2'd3;

   // Entry field positions
   localparam int unsigned ENT_DATA_LSB  = 0;
   localparam int unsigned ENT_STAT_LSB  = 8;
   localparam int unsigned ENT_STIME_LSB = 13;
   localparam int unsigned STIME_W       = 3;
   localparam int unsigned ENT_FTIME_LSB = 0;
   localparam int unsigned ENT_CMD_LSB   = 16;

   // Status byte bits
   localparam int unsigned STAT_EMPTY            = 0;
   localparam int unsigned STAT_UNDERFLOW        = 1;
   localparam int unsigned STAT_EMPTY_THRESHOLD  = 2;
   localparam int unsigned STAT_FULL             = 3;
   localparam int unsigned STAT_OVERFLOW_BLOCKED = 4;
   localparam int unsigned STAT_FULL_THRESHOLD   = 5;

   // Sniff FIFO sizing
   localparam int unsigned FIFO_DEPTH  = 16;
   localparam int unsigned FIFO_PTR_W  = 4;
   localparam int unsigned FULL_MARGIN = 2;
   localparam int unsigned EMPTY_MARK  = 2;

endpackage

/* verilog/pw_reg_bank.sv */
// Configuration registers, arm control, USB speed selection and register readback
`timescale 1ns/10ps

module pw_reg_bank (
   input  logic              cwusb_clk,
   input  logic              reset_i,
   input  pw_pkg::addr_t     reg_address,
   input  pw_pkg::bytecnt_t  reg_bytecnt,
   input  pw_pkg::byte_t     write_data,
   input  logic              reg_read,
   input  logic              reg_write,
   input  logic              reg_addrvalid,
   input  logic              match,
   input  pw_pkg::speed_t    usb_auto_speed,
   output logic              arm,
   output logic              timestamps_disable,
   output pw_pkg::pattern_t  pattern,
   output pw_pkg::pattern_t  pattern_mask,
   output logic [1:0]        pattern_action,
   output pw_pkg::byte_t     pattern_bytes,
   output pw_pkg::caplen_t   capture_len,
   output pw_pkg::tdelay_t   trigger_delay,
   output pw_pkg::twidth_t   trigger_width,
   output pw_pkg::speed_t    usb_speed,
   output logic              usb_auto_restart,
   output pw_pkg::byte_t     reg_read_data
);
   import pw_pkg::*;

   logic   wr_strobe;
   speed_t usb_speed_reg;
   speed_t usb_auto_q;

   // Replace byte idx of a register, bytes past 7 fall away
   function automatic pattern_t put_byte(pattern_t cur, bytecnt_t idx, byte_t b);
      if (idx[6:3] == 4'd0) begin
         cur[{idx[2:0], 3'b000} +: 8] = b;
      end
      return cur;
   endfunction

   function automatic byte_t get_byte(pattern_t val, bytecnt_t idx);
      byte_t b;
      b = '0;
      if (idx[6:3] == 4'd0) begin
         b = val[{idx[2:0], 3'b000} +: 8];
      end
      return b;
   endfunction

   assign wr_strobe = reg_addrvalid && reg_write;

   ////////////////////////////////////////////////////////////////////////////
   // Register writes
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge cwusb_clk) begin
      if (reset_i) begin
         arm                <= 1'b0;
         timestamps_disable <= 1'b0;
         pattern            <= '0;
         pattern_mask       <= '0;
         pattern_action     <= '0;
         pattern_bytes      <= '0;
         capture_len        <= '0;
         trigger_delay      <= '0;
         trigger_width      <= '0;
         usb_speed_reg      <= USB_SPEED_AUTO;
         usb_auto_restart   <= 1'b0;
         usb_auto_q         <= '0;
      end else begin
         usb_auto_q <= usb_auto_speed;
         if (wr_strobe) begin
            case (reg_address)
               REG_TIMESTAMPS_DISABLE: timestamps_disable <= write_data[0];
               REG_PATTERN: pattern <= put_byte(pattern, reg_bytecnt, write_data);
               REG_PATTERN_MASK: pattern_mask <= put_byte(pattern_mask, reg_bytecnt, write_data);
               REG_PATTERN_ACTION: pattern_action <=
                  2'(put_byte(pattern_t'(pattern_action), reg_bytecnt, write_data));
               REG_PATTERN_BYTES: pattern_bytes <= write_data;
               REG_CAPTURE_LEN: capture_len <=
                  caplen_t'(put_byte(pattern_t'(capture_len), reg_bytecnt, write_data));
               REG_TRIGGER_DELAY: trigger_delay <=
                  tdelay_t'(put_byte(pattern_t'(trigger_delay), reg_bytecnt, write_data));
               REG_TRIGGER_WIDTH: trigger_width <=
                  twidth_t'(put_byte(pattern_t'(trigger_width), reg_bytecnt, write_data));
               REG_USB_SPEED: usb_speed_reg <= write_data[1:0];
               default: ;
            endcase
         end

         // A host write to arm wins over a match in the same cycle
         if (wr_strobe && reg_address == REG_ARM) begin
            arm <= write_data[0];
         end else if (match) begin
            arm <= 1'b0;
         end

         usb_auto_restart <= wr_strobe && reg_address == REG_USB_SPEED &&
                             write_data == {6'b0, USB_SPEED_AUTO};
      end
   end

   // Auto mode hands speed selection to the detector
   assign usb_speed = (usb_speed_reg == USB_SPEED_AUTO) ? usb_auto_q : usb_speed_reg;

   ////////////////////////////////////////////////////////////////////////////
   // Readback, valid the cycle after the strobe
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge cwusb_clk) begin
      if (reset_i) begin
         reg_read_data <= '0;
      end else if (reg_addrvalid && reg_read) begin
         case (reg_address)
            REG_ARM: reg_read_data <= {7'b0, arm};
            REG_TIMESTAMPS_DISABLE: reg_read_data <= {7'b0, timestamps_disable};
            REG_PATTERN: reg_read_data <= get_byte(pattern, reg_bytecnt);
            REG_PATTERN_MASK: reg_read_data <= get_byte(pattern_mask, reg_bytecnt);
            REG_PATTERN_ACTION:
               reg_read_data <= get_byte(pattern_t'(pattern_action), reg_bytecnt);
            REG_PATTERN_BYTES: reg_read_data <= pattern_bytes;
            REG_CAPTURE_LEN: reg_read_data <= get_byte(pattern_t'(capture_len), reg_bytecnt);
            REG_TRIGGER_DELAY:
               reg_read_data <= get_byte(pattern_t'(trigger_delay), reg_bytecnt);
            REG_TRIGGER_WIDTH:
               reg_read_data <= get_byte(pattern_t'(trigger_width), reg_bytecnt);
            REG_USB_SPEED: reg_read_data <= {6'b0, usb_speed};
            default: reg_read_data <= '0;
         endcase
      end else begin
         reg_read_data <= '0;
      end
   end

endmodule

/* verilog/pw_capture_packer.sv */
// Capture event packing into FIFO entries, write blocking and overflow flag
`timescale 1ns/10ps

module pw_capture_packer (
   input  logic            cwusb_clk,
   input  logic            reset_i,
   input  logic            capture_wr,
   input  pw_pkg::cmd_t    capture_cmd,
   input  pw_pkg::byte_t   capture_data,
   input  pw_pkg::stat_t   capture_stat,
   input  pw_pkg::ftime_t  capture_time,
   input  logic            almost_full,
   input  logic            arm,
   output logic            fifo_wr_en,
   output pw_pkg::entry_t  fifo_din,
   output logic            overflow_blocked
);
   import pw_pkg::*;

   entry_t entry_next;
   logic   accept;

   assign accept = capture_wr && !almost_full;

   always_comb begin
      entry_next = '0;
      entry_next[ENT_CMD_LSB +: $bits(cmd_t)] = capture_cmd;
      case (capture_cmd)
         CMD_DATA: begin
            entry_next[ENT_STIME_LSB +: STIME_W]      = capture_time[STIME_W-1:0];
            entry_next[ENT_DATA_LSB +: $bits(byte_t)] = capture_data;
            entry_next[ENT_STAT_LSB +: $bits(stat_t)] = capture_stat;
         end
         CMD_STAT: begin
            // Data byte stays zero
            entry_next[ENT_STIME_LSB +: STIME_W]      = capture_time[STIME_W-1:0];
            entry_next[ENT_STAT_LSB +: $bits(stat_t)] = capture_stat;
         end
         CMD_TIME: begin
            entry_next[ENT_FTIME_LSB +: $bits(ftime_t)] = capture_time;
         end
         default: ;
      endcase
   end

   always_ff @(posedge cwusb_clk) begin
      if (accept) begin
         fifo_din <= entry_next;
      end
   end

   always_ff @(posedge cwusb_clk) begin
      if (reset_i) begin
         fifo_wr_en       <= 1'b0;
         overflow_blocked <= 1'b0;
      end else begin
         fifo_wr_en <= accept;
         // Sticky until the block is armed again
         if (capture_wr && almost_full) begin
            overflow_blocked <= 1'b1;
         end else if (arm) begin
            overflow_blocked <= 1'b0;
         end
      end
   end

endmodule

/* verilog/pw_sniff_fifo.sv */
// Synchronous sniff FIFO with registered output, occupancy count and level flags
`timescale 1ns/10ps

module pw_sniff_fifo (
   input  logic            cwusb_clk,
   input  logic            reset_i,
   input  logic            fifo_wr_en,
   input  pw_pkg::entry_t  fifo_din,
   input  logic            fifo_rd_en,
   output pw_pkg::entry_t  fifo_dout,
   output logic            fifo_empty,
   output logic            fifo_full,
   output logic            almost_full,
   output logic [4:0]      fifo_count
);
   import pw_pkg::*;

   entry_t                mem [FIFO_DEPTH];
   logic [FIFO_PTR_W-1:0] wr_ptr;
   logic [FIFO_PTR_W-1:0] rd_ptr;
   logic                  push;
   logic                  pop;

   assign push = fifo_wr_en && !fifo_full;
   assign pop  = fifo_rd_en && !fifo_empty;

   // Storage and output register
   always_ff @(posedge cwusb_clk) begin
      if (push) begin
         mem[wr_ptr] <= fifo_din;
      end
      if (pop) begin
         fifo_dout <= mem[rd_ptr];
      end
   end

   always_ff @(posedge cwusb_clk) begin
      if (reset_i) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         fifo_count <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10: fifo_count <= fifo_count + 1'b1;
            2'b01: fifo_count <= fifo_count - 1'b1;
            default: ;
         endcase
      end
   end

   assign fifo_empty = (fifo_count == 5'd0);
   assign fifo_full  = (fifo_count == 5'(FIFO_DEPTH));

   // Counts the write still sitting in the packer register, so back-to-back
   // events stop at exactly the margin
   assign almost_full = ({1'b0, fifo_count} + {5'b0, fifo_wr_en}) >=
                        6'(FIFO_DEPTH - FULL_MARGIN);

endmodule

/* verilog/pw_fifo_reader.sv */
// FIFO pop control, empty-read substitution, flush, status byte and read data mux
`timescale 1ns/10ps

module pw_fifo_reader (
   input  logic              cwusb_clk,
   input  logic              reset_i,
   input  pw_pkg::addr_t     reg_address,
   input  pw_pkg::bytecnt_t  reg_bytecnt,
   input  logic              reg_read,
   input  logic              reg_addrvalid,
   input  pw_pkg::byte_t     reg_read_data,
   input  logic              arm,
   input  pw_pkg::entry_t    fifo_dout,
   input  logic              fifo_empty,
   input  logic              fifo_full,
   input  logic              almost_full,
   input  logic [4:0]        fifo_count,
   input  logic              overflow_blocked,
   output logic              fifo_rd_en,
   output logic              arm_out,
   output pw_pkg::byte_t     read_data
);
   import pw_pkg::*;

   logic         rd_strobe;
   logic         pop_req;
   logic         empty_read;
   logic         flushing;
   logic         arm_q;
   fifo_status_t fifo_status;
   entry_t       rd_entry;
   byte_t        stat_data;

   ////////////////////////////////////////////////////////////////////////////
   // Pop decision and empty-read flag
   ////////////////////////////////////////////////////////////////////////////
   assign rd_strobe = reg_addrvalid && reg_read && reg_address == REG_SNIFF_FIFO_RD;

   // First byte of each four-byte read pops, never while the flag is pending
   assign pop_req    = rd_strobe && reg_bytecnt[1:0] == 2'd0 && !fifo_empty && !empty_read;
   assign fifo_rd_en = pop_req || (flushing && !fifo_empty);

   always_ff @(posedge cwusb_clk) begin
      if (reset_i) begin
         empty_read <= 1'b0;
      end else if (rd_strobe && reg_bytecnt[1:0] == 2'd0 && fifo_empty) begin
         empty_read <= 1'b1;
      end else if (rd_strobe && reg_bytecnt[1:0] == 2'd3 && !fifo_empty) begin
         // Last byte carries no data, so clearing here is safe
         empty_read <= 1'b0;
      end
   end

   // Flush on a fresh arm, one entry per cycle
   always_ff @(posedge cwusb_clk) begin
      if (reset_i) begin
         arm_q    <= 1'b0;
         flushing <= 1'b0;
      end else begin
         arm_q <= arm;
         if (fifo_empty) begin
            flushing <= 1'b0;
         end else if (arm && !arm_q) begin
            flushing <= 1'b1;
         end
      end
   end

   assign arm_out = arm_q && !flushing;

   ////////////////////////////////////////////////////////////////////////////
   // Status byte and read data
   ////////////////////////////////////////////////////////////////////////////
   assign fifo_status[STAT_EMPTY]            = fifo_empty;
   assign fifo_status[STAT_UNDERFLOW]        = 1'b0;
   assign fifo_status[STAT_EMPTY_THRESHOLD]  = fifo_count <= 5'(EMPTY_MARK) && !fifo_empty;
   assign fifo_status[STAT_FULL]             = fifo_full;
   assign fifo_status[STAT_OVERFLOW_BLOCKED] = overflow_blocked;
   assign fifo_status[STAT_FULL_THRESHOLD]   = almost_full && !fifo_full;

   always_ff @(posedge cwusb_clk) begin
      if (reset_i) begin
         stat_data <= '0;
      end else if (reg_addrvalid && reg_read && reg_address == REG_SNIFF_FIFO_STAT) begin
         stat_data <= {2'b00, fifo_status};
      end else begin
         stat_data <= '0;
      end
   end

   always_comb begin
      rd_entry = fifo_dout;
      if (empty_read) begin
         rd_entry = '0;
         rd_entry[ENT_CMD_LSB +: $bits(cmd_t)]   = CMD_STRM;
         rd_entry[ENT_DATA_LSB +: $bits(byte_t)] = STRM_EMPTY;
      end
   end

   always_comb begin
      if (reg_address == REG_SNIFF_FIFO_RD) begin
         case (reg_bytecnt[1:0])
            2'd0: read_data = rd_entry[7:0];
            2'd1: read_data = rd_entry[15:8];
            2'd2: read_data = {fifo_status, rd_entry[17:16]};
            default: read_data = '0;
         endcase
      end else if (reg_address == REG_SNIFF_FIFO_STAT) begin
         read_data = stat_data;
      end else begin
         read_data = reg_read_data;
      end
   end

endmodule

/* verilog/pw_top.sv */
// Sniffer register block top level with register bank, packer, FIFO and reader
`timescale 1ns/10ps

module pw_top (
   input  logic              cwusb_clk,
   input  logic              reset_i,
   // Host register port
   input  pw_pkg::addr_t     reg_address,
   input  pw_pkg::bytecnt_t  reg_bytecnt,
   input  pw_pkg::byte_t     write_data,
   input  logic              reg_read,
   input  logic              reg_write,
   input  logic              reg_addrvalid,
   // Front-end capture events
   input  logic              capture_wr,
   input  pw_pkg::cmd_t      capture_cmd,
   input  pw_pkg::byte_t     capture_data,
   input  pw_pkg::stat_t     capture_stat,
   input  pw_pkg::ftime_t    capture_time,
   input  logic              match,
   input  pw_pkg::speed_t    usb_auto_speed,
   output pw_pkg::byte_t     read_data,
   output logic              arm_out,
   output logic              timestamps_disable,
   output pw_pkg::pattern_t  pattern,
   output pw_pkg::pattern_t  pattern_mask,
   output logic [1:0]        pattern_action,
   output pw_pkg::byte_t     pattern_bytes,
   output pw_pkg::caplen_t   capture_len,
   output pw_pkg::tdelay_t   trigger_delay,
   output pw_pkg::twidth_t   trigger_width,
   output pw_pkg::speed_t    usb_speed,
   output logic              usb_auto_restart,
   output logic              fifo_full,
   output logic              overflow_blocked
);
   import pw_pkg::*;

   logic       arm;
   byte_t      reg_read_data;
   logic       fifo_wr_en;
   entry_t     fifo_din;
   logic       fifo_rd_en;
   entry_t     fifo_dout;
   logic       fifo_empty;
   logic       almost_full;
   logic [4:0] fifo_count;

   pw_reg_bank i_reg_bank (
      .cwusb_clk          (cwusb_clk),
      .reset_i            (reset_i),
      .reg_address        (reg_address),
      .reg_bytecnt        (reg_bytecnt),
      .write_data         (write_data),
      .reg_read           (reg_read),
      .reg_write          (reg_write),
      .reg_addrvalid      (reg_addrvalid),
      .match              (match),
      .usb_auto_speed     (usb_auto_speed),
      .arm                (arm),
      .timestamps_disable (timestamps_disable),
      .pattern            (pattern),
      .pattern_mask       (pattern_mask),
      .pattern_action     (pattern_action),
      .pattern_bytes      (pattern_bytes),
      .capture_len        (capture_len),
      .trigger_delay      (trigger_delay),
      .trigger_width      (trigger_width),
      .usb_speed          (usb_speed),
      .usb_auto_restart   (usb_auto_restart),
      .reg_read_data      (reg_read_data)
   );

   pw_capture_packer i_packer (
      .cwusb_clk        (cwusb_clk),
      .reset_i          (reset_i),
      .capture_wr       (capture_wr),
      .capture_cmd      (capture_cmd),
      .capture_data     (capture_data),
      .capture_stat     (capture_stat),
      .capture_time     (capture_time),
      .almost_full      (almost_full),
      .arm              (arm),
      .fifo_wr_en       (fifo_wr_en),
      .fifo_din         (fifo_din),
      .overflow_blocked (overflow_blocked)
   );

   pw_sniff_fifo i_sniff_fifo (
      .cwusb_clk   (cwusb_clk),
      .reset_i     (reset_i),
      .fifo_wr_en  (fifo_wr_en),
      .fifo_din    (fifo_din),
      .fifo_rd_en  (fifo_rd_en),
      .fifo_dout   (fifo_dout),
      .fifo_empty  (fifo_empty),
      .fifo_full   (fifo_full),
      .almost_full (almost_full),
      .fifo_count  (fifo_count)
   );

   pw_fifo_reader i_fifo_reader (
      .cwusb_clk        (cwusb_clk),
      .reset_i          (reset_i),
      .reg_address      (reg_address),
      .reg_bytecnt      (reg_bytecnt),
      .reg_read         (reg_read),
      .reg_addrvalid    (reg_addrvalid),
      .reg_read_data    (reg_read_data),
      .arm              (arm),
      .fifo_dout        (fifo_dout),
      .fifo_empty       (fifo_empty),
      .fifo_full        (fifo_full),
      .almost_full      (almost_full),
      .fifo_count       (fifo_count),
      .overflow_blocked (overflow_blocked),
      .fifo_rd_en       (fifo_rd_en),
      .arm_out          (arm_out),
      .read_data        (read_data)
   );

endmodule

/* verification/pw_tb_tasks.svh */
// Host bus read and write tasks, typed compare tasks and the random number generator

// Linear congruential generator
function automatic logic [31:0] next_rand();
   rand_state = rand_state * 32'd1103515245 + 32'd12345;
   return rand_state;
endfunction

task automatic host_write(input addr_t addr, input bytecnt_t cnt, input byte_t data);
   @(posedge cwusb_clk);
   #5;
   reg_address   = addr;
   reg_bytecnt   = cnt;
   write_data    = data;
   reg_addrvalid = 1'b1;
   reg_write     = 1'b1;
   @(posedge cwusb_clk);
   #5;
   reg_write     = 1'b0;
   reg_addrvalid = 1'b0;
endtask

// Address and byte count stay put through the data cycle
task automatic host_read(input addr_t addr, input bytecnt_t cnt, output byte_t data);
   @(posedge cwusb_clk);
   #5;
   reg_address   = addr;
   reg_bytecnt   = cnt;
   reg_addrvalid = 1'b1;
   reg_read      = 1'b1;
   @(posedge cwusb_clk);
   #5;
   reg_read      = 1'b0;
   reg_addrvalid = 1'b0;
   @(negedge cwusb_clk);
   data = read_data;
endtask

task automatic check_byte(input string what, input byte_t exp, input byte_t act);
   if (act !== exp) begin
      report_failure($sformatf("Mismatch in %s, %s: expected 0x%02h, actual 0x%02h",
                               test_name, what, exp, act));
   end
endtask

task automatic check_entry(input string what, input entry_t exp, input entry_t act);
   if (act !== exp) begin
      report_failure($sformatf("Mismatch in %s, %s: expected 0x%05h, actual 0x%05h",
                               test_name, what, exp, act));
   end
endtask

task automatic check_bit(input string what, input logic exp, input logic act);
   if (act !== exp) begin
      report_failure($sformatf("Mismatch in %s, %s: expected %b, actual %b",
                               test_name, what, exp, act));
   end
endtask

task automatic check_speed(input string what, input speed_t exp, input speed_t act);
   if (act !== exp) begin
      report_failure($sformatf("Mismatch in %s, %s: expected %0d, actual %0d",
                               test_name, what, exp, act));
   end
endtask

task automatic check_pattern(input string what, input pattern_t exp, input pattern_t act);
   if (act !== exp) begin
      report_failure($sformatf("Mismatch in %s, %s: expected 0x%016h, actual 0x%016h",
                               test_name, what, exp, act));
   end
endtask

/* verification/pw_tb.sv */
// Testbench for the sniffer register block with reference model, comparing process and checks
`timescale 1ns/10ps

module pw_tb;
   import pw_pkg::*;

   logic        cwusb_clk = 1'b0;
   logic        reset_i;
   addr_t       reg_address;
   bytecnt_t    reg_bytecnt;
   byte_t       write_data;
   logic        reg_read;
   logic        reg_write;
   logic        reg_addrvalid;
   logic        capture_wr;
   cmd_t        capture_cmd;
   byte_t       capture_data;
   stat_t       capture_stat;
   ftime_t      capture_time;
   logic        match;
   speed_t      usb_auto_speed;
   byte_t       read_data;
   logic        arm_out;
   logic        timestamps_disable;
   pattern_t    pattern;
   pattern_t    pattern_mask;
   logic [1:0]  pattern_action;
   byte_t       pattern_bytes;
   caplen_t     capture_len;
   tdelay_t     trigger_delay;
   twidth_t     trigger_width;
   speed_t      usb_speed;
   logic        usb_auto_restart;
   logic        fifo_full;
   logic        overflow_blocked;

   entry_t      exp_q[$];
   entry_t      got_q[$];
   logic [31:0] rand_state = 32'd12;
   string       test_name = "reset";

   pw_top i_dut (.*);

   always #50 cwusb_clk = ~cwusb_clk;

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("TEST FAILED");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   `include "pw_tb_tasks.svh"

   ////////////////////////////////////////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////////////////////////////////////////
   function automatic entry_t expected_entry(cmd_t cmd, byte_t data, stat_t stat, ftime_t t);
      entry_t e;
      e = '0;
      e[17:16] = cmd;
      case (cmd)
         CMD_DATA: begin
            e[15:13] = t[2:0];
            e[12:8]  = stat;
            e[7:0]   = data;
         end
         CMD_STAT: begin
            e[15:13] = t[2:0];
            e[12:8]  = stat;
         end
         CMD_TIME: e[15:0] = t;
         default: ;
      endcase
      return e;
   endfunction

   // Status byte for a given occupancy with no write pending
   function automatic byte_t expected_status(int count, logic ovf);
      byte_t s;
      s = '0;
      s[0] = (count == 0);
      s[2] = (count != 0 && count <= 2);
      s[3] = (count == 16);
      s[4] = ovf;
      s[5] = (count >= 14 && count < 16);
      return s;
   endfunction

   // Comparing process, entries arrive at the falling edge
   always @(posedge cwusb_clk) begin
      if (got_q.size() > 0) begin
         if (exp_q.size() == 0) begin
            report_failure("FIFO read returned an entry that was never captured");
         end else begin
            check_entry("FIFO entry", exp_q.pop_front(), got_q.pop_front());
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus helpers
   ////////////////////////////////////////////////////////////////////////////
   task automatic write_and_readback(input addr_t addr, input int nbytes, input int width,
                                     output pattern_t value);
      pattern_t written;
      byte_t    b;
      written = '0;
      for (int k = 0; k < nbytes; k++) begin
         b = byte_t'(next_rand() >> 16);
         written[8*k +: 8] = b;
         host_write(addr, bytecnt_t'(k), b);
      end
      // Bits above the register width are dropped
      value = written & ((64'd1 << width) - 64'd1);
      for (int k = 0; k < nbytes; k++) begin
         host_read(addr, bytecnt_t'(k), b);
         check_byte($sformatf("readback byte %0d", k), value[8*k +: 8], b);
      end
   endtask

   // Back-to-back events, only the first keep of them end up in the FIFO
   task automatic capture_burst(input int count, input int keep);
      cmd_t   cmd;
      byte_t  data;
      stat_t  stat;
      ftime_t t;
      for (int i = 0; i < count; i++) begin
         cmd  = cmd_t'((next_rand() >> 16) % 32'd3);
         data = byte_t'(next_rand() >> 16);
         stat = stat_t'(next_rand() >> 16);
         t    = ftime_t'(next_rand() >> 8);
         @(posedge cwusb_clk);
         #5;
         capture_wr   = 1'b1;
         capture_cmd  = cmd;
         capture_data = data;
         capture_stat = stat;
         capture_time = t;
         if (i < keep) begin
            exp_q.push_back(expected_entry(cmd, data, stat, t));
         end
      end
      @(posedge cwusb_clk);
      #5;
      capture_wr = 1'b0;
      repeat (3) @(posedge cwusb_clk);
   endtask

   task automatic read_fifo_entry(input int remaining, input logic ovf);
      byte_t b0;
      byte_t b1;
      byte_t b2;
      byte_t b3;
      host_read(REG_SNIFF_FIFO_RD, 7'd0, b0);
      host_read(REG_SNIFF_FIFO_RD, 7'd1, b1);
      host_read(REG_SNIFF_FIFO_RD, 7'd2, b2);
      host_read(REG_SNIFF_FIFO_RD, 7'd3, b3);
      check_byte("status in FIFO byte 2", expected_status(remaining, ovf), {2'b00, b2[7:2]});
      check_byte("FIFO byte 3", 8'h00, b3);
      got_q.push_back({b2[1:0], b1, b0});
   endtask

   task automatic verify_status(input int count, input logic ovf);
      byte_t b;
      host_read(REG_SNIFF_FIFO_STAT, 7'd0, b);
      check_byte("status register", expected_status(count, ovf), b);
   endtask

   task automatic wait_compare_done();
      int cycles;
      cycles = 0;
      while (got_q.size() != 0) begin
         if (cycles >= 10) begin
            report_failure("Comparing process did not take the read entries in time");
         end
         @(negedge cwusb_clk);
         cycles++;
      end
      if (exp_q.size() != 0) begin
         report_failure("Captured entries were never read back from the FIFO");
      end
   endtask

   task automatic wait_arm_out(input logic level, input int max_cycles, output int cycles);
      cycles = 0;
      while (arm_out !== level) begin
         if (cycles >= max_cycles) begin
            report_failure($sformatf("arm_out did not go to %b within %0d cycles",
                                     level, max_cycles));
         end
         @(negedge cwusb_clk);
         cycles++;
      end
   endtask

   task automatic drive_auto_speed(input speed_t s);
      @(posedge cwusb_clk);
      #5;
      usb_auto_speed = s;
      repeat (2) @(posedge cwusb_clk);
      @(negedge cwusb_clk);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////////////////////
   initial begin
      pattern_t val;
      byte_t    b;
      int       cycles;

      reset_i        = 1'b1;
      reg_address    = '0;
      reg_bytecnt    = '0;
      write_data     = '0;
      reg_read       = 1'b0;
      reg_write      = 1'b0;
      reg_addrvalid  = 1'b0;
      capture_wr     = 1'b0;
      capture_cmd    = '0;
      capture_data   = '0;
      capture_stat   = '0;
      capture_time   = '0;
      match          = 1'b0;
      usb_auto_speed = '0;
      repeat (8) @(posedge cwusb_clk);
      #5;
      reset_i = 1'b0;

      test_name = "register readback";
      write_and_readback(REG_PATTERN, 8, 64, val);
      check_pattern("pattern port", val, pattern);
      write_and_readback(REG_PATTERN_MASK, 8, 64, val);
      check_pattern("pattern_mask port", val, pattern_mask);
      write_and_readback(REG_CAPTURE_LEN, 3, 16, val);
      check_pattern("capture_len port", val, pattern_t'(capture_len));
      write_and_readback(REG_TRIGGER_DELAY, 3, 20, val);
      check_pattern("trigger_delay port", val, pattern_t'(trigger_delay));
      write_and_readback(REG_TRIGGER_WIDTH, 3, 16, val);
      check_pattern("trigger_width port", val, pattern_t'(trigger_width));
      write_and_readback(REG_PATTERN_BYTES, 1, 8, val);
      check_pattern("pattern_bytes port", val, pattern_t'(pattern_bytes));

      // Upper bits of the action byte fall away
      host_write(REG_PATTERN_ACTION, 7'd0, 8'hfe);
      host_read(REG_PATTERN_ACTION, 7'd0, b);
      check_byte("REG_PATTERN_ACTION readback", 8'h02, b);
      check_pattern("pattern_action port", 64'd2, pattern_t'(pattern_action));
      host_write(REG_TIMESTAMPS_DISABLE, 7'd0, 8'h01);
      host_read(REG_TIMESTAMPS_DISABLE, 7'd0, b);
      check_byte("REG_TIMESTAMPS_DISABLE readback", 8'h01, b);
      check_bit("timestamps_disable port", 1'b1, timestamps_disable);

      test_name = "usb speed";
      host_write(REG_USB_SPEED, 7'd0, {6'b0, USB_SPEED_AUTO});
      cycles = 0;
      while (usb_auto_restart !== 1'b1) begin
         if (cycles >= 4) begin
            report_failure("usb_auto_restart pulse did not follow the auto speed write");
         end
         @(negedge cwusb_clk);
         cycles++;
      end
      @(posedge cwusb_clk);
      @(negedge cwusb_clk);
      check_bit("usb_auto_restart one cycle wide", 1'b0, usb_auto_restart);
      drive_auto_speed(2'd2);
      check_speed("auto mode follows detector", 2'd2, usb_speed);
      drive_auto_speed(2'd1);
      check_speed("auto mode follows detector", 2'd1, usb_speed);
      host_write(REG_USB_SPEED, 7'd0, 8'd1);
      drive_auto_speed(2'd0);
      check_speed("fixed speed", 2'd1, usb_speed);
      drive_auto_speed(2'd2);
      check_speed("fixed speed", 2'd1, usb_speed);
      host_read(REG_USB_SPEED, 7'd0, b);
      check_byte("REG_USB_SPEED readback", 8'd1, b);

      test_name = "arm and match";
      host_write(REG_ARM, 7'd0, 8'd1);
      wait_arm_out(1'b1, 10, cycles);
      @(posedge cwusb_clk);
      #5;
      match = 1'b1;
      @(posedge cwusb_clk);
      #5;
      match = 1'b0;
      wait_arm_out(1'b0, 10, cycles);
      host_read(REG_ARM, 7'd0, b);
      check_byte("REG_ARM after match", 8'h00, b);

      test_name = "capture path";
      capture_burst(10, 10);
      verify_status(10, 1'b0);
      for (int i = 0; i < 10; i++) begin
         read_fifo_entry(9 - i, 1'b0);
      end
      wait_compare_done();
      verify_status(0, 1'b0);

      test_name = "overflow";
      capture_burst(20, 14);
      check_bit("overflow_blocked after overfill", 1'b1, overflow_blocked);
      check_bit("fifo_full after overfill", 1'b0, fifo_full);
      verify_status(14, 1'b1);
      for (int i = 0; i < 14; i++) begin
         read_fifo_entry(13 - i, 1'b1);
      end
      wait_compare_done();
      verify_status(0, 1'b1);

      // Refill, then arm must wait for the flush
      test_name = "flush on arm";
      capture_burst(20, 0);
      verify_status(14, 1'b1);
      host_write(REG_ARM, 7'd0, 8'd1);
      wait_arm_out(1'b1, 40, cycles);
      if (cycles < 14) begin
         report_failure("arm_out rose before the FIFO flush could finish");
      end
      verify_status(0, 1'b0);
      check_bit("overflow_blocked after arm", 1'b0, overflow_blocked);

      test_name = "empty read";
      exp_q.push_back({CMD_STRM, 8'h00, STRM_EMPTY});
      read_fifo_entry(0, 1'b0);
      wait_compare_done();

      test_name = "end";
      $display("TEST PASSED");
      $finish;
   end

endmodule

/* vlog.f */
+incdir+verification
verilog/pw_pkg.sv
verilog/pw_reg_bank.sv
verilog/pw_capture_packer.sv
verilog/pw_sniff_fifo.sv
verilog/pw_fifo_reader.sv
verilog/pw_top.sv
verification/pw_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module pw_tb -f vlog.f -o pw_sim || exit 1
sim_out="$(./obj_dir/pw_sim 2>&1)"
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -q "TEST PASSED" \
   && echo "Simulation run passed" \
   || { echo "Simulation run failed"; exit 1; }
